/* common/rv_pkg.sv */
// widths, reset address, opcode, alu operation, memory width and cpu state types
`default_nettype none

package rv_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    localparam word_t reset_addr = '0;

    // major opcodes of the rv32i base set
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_imm,
        alu_link
    } alu_op_e;

    // encodings follow funct3 of loads and stores
    typedef enum logic [2:0] {
        mem_byte          = 3'b000,
        mem_half          = 3'b001,
        mem_word          = 3'b010,
        mem_byte_unsigned = 3'b100,
        mem_half_unsigned = 3'b101
    } mem_width_e;

    // one-hot instruction sequence
    typedef enum logic [5:0] {
        st_fetch      = 6'b000001,
        st_wait_instr = 6'b000010,
        st_decode     = 6'b000100,
        st_execute    = 6'b001000,
        st_write_back = 6'b010000,
        st_next_pc    = 6'b100000
    } cpu_state_e;

endpackage

`default_nettype wire

/* common/decode_if.sv */
// decoded instruction bundle with decoder, exec and ctrl modports
`default_nettype none

interface decode_if;
    import rv_pkg::*;

    opcode_e    opcode;
    alu_op_e    alu_op;
    logic       use_imm;
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    mem_width_e width;
    logic       writes_rd;

    modport decoder (
        output opcode, alu_op, use_imm, imm, rs1, rs2, rd, funct3, width, writes_rd
    );

    modport exec (
        input opcode, alu_op, use_imm, imm, funct3, width
    );

    modport ctrl (
        input opcode, rd, writes_rd
    );

endinterface

`default_nettype wire

/* core/rv_decoder.sv */
// rv32i decoder: field extraction, immediates, alu operation and width mapping
`default_nettype none

module rv_decoder (
    input rv_pkg::word_t instr,
    decode_if.decoder    dec
);
    import rv_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // shared by register and immediate arithmetic
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign dec.opcode = opcode_e'(instr[6:0]);
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];

    always_comb begin
        dec.imm       = '0;
        dec.alu_op    = alu_add;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b0;
        case (instr[6:0])
            opc_load, opc_jalr: begin
                dec.imm       = imm_i;
                dec.alu_op    = (instr[6:0] == opc_jalr) ? alu_link : alu_add;
                dec.writes_rd = 1'b1;
            end
            opc_store: dec.imm = imm_s;
            opc_op: begin
                dec.use_imm   = 1'b0;
                dec.alu_op    = alu_from_funct3(instr[14:12], instr[30]);
                dec.writes_rd = 1'b1;
            end
            opc_op_imm: begin
                dec.imm       = imm_i;
                // funct7 bit only matters for the right shift
                dec.alu_op    = alu_from_funct3(instr[14:12],
                                                instr[30] & (instr[14:12] == 3'b101));
                dec.writes_rd = 1'b1;
            end
            opc_branch: begin
                dec.imm     = imm_b;
                dec.use_imm = 1'b0;
            end
            opc_jal: begin
                dec.imm       = imm_j;
                dec.alu_op    = alu_link;
                dec.writes_rd = 1'b1;
            end
            opc_lui, opc_auipc: begin
                dec.imm       = imm_u;
                dec.alu_op    = (instr[6:0] == opc_lui) ? alu_pass_imm : alu_add;
                dec.writes_rd = 1'b1;
            end
            default: dec.use_imm = 1'b0;
        endcase
        // x0 is never a write target
        if (instr[11:7] == '0) begin
            dec.writes_rd = 1'b0;
        end
    end

    always_comb begin
        case (instr[14:12])
            3'b000:  dec.width = mem_byte;
            3'b001:  dec.width = mem_half;
            3'b100:  dec.width = mem_byte_unsigned;
            3'b101:  dec.width = mem_half_unsigned;
            default: dec.width = mem_word;
        endcase
    end

endmodule

`default_nettype wire

/* core/rv_alu.sv */
// integer alu result, branch decision and next pc
`default_nettype none

module rv_alu (
    decode_if.exec         dec,
    input  rv_pkg::word_t  rs1_val,
    input  rv_pkg::word_t  rs2_val,
    input  rv_pkg::word_t  pc,
    output rv_pkg::word_t  alu_result,
    output rv_pkg::word_t  next_pc
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      pc_plus4;
    word_t      jalr_target;
    logic [4:0] shamt;
    logic       taken;

    // auipc is the only user of pc as first operand
    assign op_a        = (dec.opcode == opc_auipc) ? pc : rs1_val;
    assign op_b        = dec.use_imm ? dec.imm : rs2_val;
    assign shamt       = op_b[4:0];
    assign pc_plus4    = pc + word_t'(4);
    assign jalr_target = rs1_val + dec.imm;

    always_comb begin
        case (dec.alu_op)
            alu_add:      alu_result = op_a + op_b;
            alu_sub:      alu_result = op_a - op_b;
            alu_sll:      alu_result = op_a << shamt;
            alu_slt:      alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:     alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:      alu_result = op_a ^ op_b;
            alu_srl:      alu_result = op_a >> shamt;
            alu_sra:      alu_result = word_t'($signed(op_a) >>> shamt);
            alu_or:       alu_result = op_a | op_b;
            alu_and:      alu_result = op_a & op_b;
            alu_pass_imm: alu_result = dec.imm;
            alu_link:     alu_result = pc_plus4;
            default:      alu_result = '0;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_val == rs2_val;
            3'b001:  taken = rs1_val != rs2_val;
            3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
            3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
            3'b110:  taken = rs1_val < rs2_val;
            3'b111:  taken = rs1_val >= rs2_val;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            opc_branch: next_pc = taken ? pc + dec.imm : pc_plus4;
            opc_jal:    next_pc = pc + dec.imm;
            opc_jalr:   next_pc = {jalr_target[xlen-1:1], 1'b0};
            default:    next_pc = pc_plus4;
        endcase
    end

endmodule

`default_nettype wire

/* core/rv_regfile.sv */
// 31 general registers, two asynchronous read ports and one write port
`default_nettype none

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::reg_idx_t rd_idx,
    input  logic             rd_we,
    input  rv_pkg::word_t    rd_data,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val
);
    import rv_pkg::*;

    // no storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rd_we && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* core/rv_mem_align.sv */
// store lane placement with byte mask, load lane selection with extension
`default_nettype none

module rv_mem_align (
    decode_if.exec         dec,
    input  rv_pkg::word_t  alu_result,
    input  rv_pkg::word_t  rs2_val,
    input  rv_pkg::word_t  mem_dout,
    output rv_pkg::word_t  store_data,
    output logic [3:0]     store_mask,
    output rv_pkg::word_t  load_data
);
    import rv_pkg::*;

    logic [1:0]  lane;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign lane = alu_result[1:0];

    // value goes to every lane, the mask picks the one written
    always_comb begin
        case (dec.width)
            mem_byte: begin
                store_data = {4{rs2_val[7:0]}};
                store_mask = 4'b0001 << lane;
            end
            mem_half: begin
                store_data = {2{rs2_val[15:0]}};
                store_mask = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_data = rs2_val;
                store_mask = 4'b1111;
            end
        endcase
    end

    assign load_byte = mem_dout[8*lane +: 8];
    assign load_half = lane[1] ? mem_dout[31:16] : mem_dout[15:0];

    always_comb begin
        case (dec.width)
            mem_byte:          load_data = {{24{load_byte[7]}}, load_byte};
            mem_byte_unsigned: load_data = {24'b0, load_byte};
            mem_half:          load_data = {{16{load_half[15]}}, load_half};
            mem_half_unsigned: load_data = {16'b0, load_half};
            default:           load_data = mem_dout;
        endcase
    end

endmodule

`default_nettype wire

/* core/rv_control.sv */
// instruction sequencer: pc, instruction register, memory strobes and register write-back
`default_nettype none

module rv_control (
    input  logic             clk,
    input  logic             resetn,
    input  logic             mem_valid,
    input  logic             mem_ready,
    input  rv_pkg::word_t    mem_dout,
    decode_if.ctrl           dec,
    input  rv_pkg::word_t    alu_result,
    input  rv_pkg::word_t    next_pc,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    load_data,
    input  logic [3:0]       store_mask,
    output rv_pkg::word_t    instr,
    output rv_pkg::word_t    pc,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    mem_din,
    output logic             mem_rd,
    output logic [3:0]       mem_wmask,
    output logic             rd_we,
    output rv_pkg::reg_idx_t rd_idx,
    output rv_pkg::word_t    rd_data
);
    import rv_pkg::*;

    cpu_state_e state;
    word_t      instr_reg;
    logic       is_load;
    logic       is_store;

    assign is_load  = dec.opcode == opc_load;
    assign is_store = dec.opcode == opc_store;

    // fetched word goes straight to the decoder while it is captured
    assign instr  = (state == st_wait_instr) ? mem_dout : instr_reg;
    assign rd_idx = dec.rd;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= st_fetch;
            pc        <= reset_addr;
            mem_addr  <= reset_addr;
            mem_rd    <= 1'b1;
            mem_wmask <= 4'b0;
            rd_we     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (mem_valid) begin
                        mem_rd <= 1'b0;
                        state  <= st_wait_instr;
                    end
                end
                st_wait_instr: state <= st_decode;
                st_decode: begin
                    // load/store address, or unused otherwise
                    mem_addr <= alu_result;
                    mem_rd   <= is_load;
                    state    <= st_execute;
                end
                st_execute: begin
                    if (!is_load || mem_valid) begin
                        state <= st_write_back;
                    end
                end
                st_write_back: begin
                    mem_rd <= 1'b0;
                    if (is_store) begin
                        if (mem_ready) begin
                            mem_wmask <= store_mask;
                            state     <= st_next_pc;
                        end
                    end else begin
                        rd_we <= dec.writes_rd;
                        state <= st_next_pc;
                    end
                end
                st_next_pc: begin
                    // a store completes once memory reports valid
                    if (!is_store || mem_valid) begin
                        mem_wmask <= 4'b0;
                        rd_we     <= 1'b0;
                        pc        <= next_pc;
                        mem_addr  <= next_pc;
                        mem_rd    <= 1'b1;
                        state     <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait_instr) begin
            instr_reg <= mem_dout;
        end
        if (state == st_write_back) begin
            mem_din <= store_data;
            rd_data <= is_load ? load_data : alu_result;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_top.sv */
// rv32i multicycle core top level with plain memory ports
`default_nettype none

module rv_top (
    input  logic          clk,
    input  logic          resetn,
    input  logic          mem_valid,
    input  logic          mem_ready,
    input  rv_pkg::word_t mem_dout,
    output logic          mem_rd,
    output logic [3:0]    mem_wmask,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_din,
    output rv_pkg::word_t pc
);
    import rv_pkg::*;

    word_t      instr;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      alu_result;
    word_t      next_pc;
    word_t      store_data;
    word_t      load_data;
    logic [3:0] store_mask;
    logic       rd_we;
    reg_idx_t   rd_idx;
    word_t      rd_data;

    decode_if dec_bus ();

    rv_decoder rv_decoder_i (
        .instr (instr),
        .dec   (dec_bus.decoder)
    );

    rv_regfile rv_regfile_i (
        .clk     (clk),
        .rs1_idx (dec_bus.rs1),
        .rs2_idx (dec_bus.rs2),
        .rd_idx  (rd_idx),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv_alu rv_alu_i (
        .dec        (dec_bus.exec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .pc         (pc),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    rv_mem_align rv_mem_align_i (
        .dec        (dec_bus.exec),
        .alu_result (alu_result),
        .rs2_val    (rs2_val),
        .mem_dout   (mem_dout),
        .store_data (store_data),
        .store_mask (store_mask),
        .load_data  (load_data)
    );

    rv_control rv_control_i (
        .clk        (clk),
        .resetn     (resetn),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_dout   (mem_dout),
        .dec        (dec_bus.ctrl),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .store_data (store_data),
        .load_data  (load_data),
        .store_mask (store_mask),
        .instr      (instr),
        .pc         (pc),
        .mem_addr   (mem_addr),
        .mem_din    (mem_din),
        .mem_rd     (mem_rd),
        .mem_wmask  (mem_wmask),
        .rd_we      (rd_we),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// free-running 20 ns testbench clock
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

`default_nettype wire

/* verification/tb_rv_top.sv */
// testbench for the rv32i core: memory model, program generator, reference model and checks
`default_nettype none

module tb_rv_top;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int mem_words = 1024;

    logic       clk;
    logic       resetn = 1'b0;
    logic       mem_valid = 1'b0;
    logic       mem_ready = 1'b0;
    word_t      mem_dout;
    logic       mem_rd;
    logic [3:0] mem_wmask;
    word_t      mem_addr;
    word_t      mem_din;
    word_t      pc;

    word_t  mem [0:mem_words-1];
    word_t  image [0:mem_words-1];
    word_t  mmem [0:mem_words-1];
    word_t  mx [0:31];
    word_t  dut_fetch [$];
    word_t  ref_fetch [$];
    word_t  dut_wr [$];
    word_t  ref_wr [$];
    integer seed = 32095;
    int     code_w;
    word_t  halt_addr;
    logic   load_prog = 1'b0;
    logic   logging = 1'b0;
    logic   timed_out = 1'b0;
    string  cur_test;
    int     test_errors;
    int     errors = 0;
    int     tests_run = 0;

    tb_clock tb_clock_i (.clk(clk));

    rv_top rv_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_dout  (mem_dout),
        .mem_rd    (mem_rd),
        .mem_wmask (mem_wmask),
        .mem_addr  (mem_addr),
        .mem_din   (mem_din),
        .pc        (pc)
    );

    assign mem_dout = mem[mem_addr[11:2]];

    // random back-pressure from the memory side
    always @(negedge clk) begin
        logic [31:0] r;
        r = $random(seed);
        mem_valid <= r[0];
        mem_ready <= r[1];
    end

    function automatic word_t bytemask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // memory writes, plus fetch and write logging
    always @(posedge clk) begin
        if (load_prog) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= image[i];
            end
        end else if (mem_wmask != 4'b0 && mem_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wmask[b]) begin
                    mem[mem_addr[11:2]][8*b +: 8] <= mem_din[8*b +: 8];
                end
            end
            if (logging) begin
                dut_wr.push_back(mem_addr & 32'hffff_fffc);
                dut_wr.push_back({28'b0, mem_wmask});
                dut_wr.push_back(mem_din & bytemask(mem_wmask));
            end
        end
        if (logging && mem_rd && mem_valid && mem_addr == pc && pc != halt_addr) begin
            dut_fetch.push_back(mem_addr);
        end
    end

    function automatic int urand(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic word_t enc_i(input int imm, input int rs1, input int f3,
                                    input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t enc_r(input int alt, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t enc_s(input int off, input int rs2, input int rs1, input int f3);
        return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t enc_u(input int imm20, input int rd, input int opc);
        return {imm20[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input word_t ins);
        image[code_w] = ins;
        code_w++;
    endtask

    // x13 points at load sources, x14 at the result area
    task automatic build_program(input int kind);
        int rd;
        int f3;
        int lane;
        int imm;
        int sel;
        int src;
        int load_f3 [5] = '{0, 4, 1, 5, 2};
        int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        for (int i = 0; i < mem_words; i++) begin
            image[i] = $random(seed);
        end
        code_w = 0;
        for (int k = 1; k <= 12; k++) begin
            emit(enc_u(urand(65536) * 16 + urand(16), k, 7'h37));
            emit(enc_i(urand(4096), k, 0, k, 7'h13));
        end
        emit(enc_i(32'h700, 0, 0, 13, 7'h13));
        emit(enc_i(32'h400, 0, 0, 14, 7'h13));
        emit(enc_i(urand(4096), 0, 0, 15, 7'h13));
        for (int n = 0; n < 24 && kind != 0; n++) begin
            rd = urand(13);
            f3 = urand(8);
            case (kind)
                1: begin
                    if (n == 5) begin
                        // custom-0 opcode aimed at x15 must leave it untouched
                        emit(32'h0000078b);
                    end
                    if (n % 2 == 0) begin
                        emit(enc_r((f3 == 0 || f3 == 5) ? urand(2) : 0,
                                   1 + urand(15), 1 + urand(15), f3, rd));
                    end else begin
                        imm = urand(4096);
                        if (f3 == 1) imm = imm % 32;
                        if (f3 == 5) imm = imm % 32 + 32'h400 * urand(2);
                        emit(enc_i(imm, 1 + urand(15), f3, rd, 7'h13));
                    end
                end
                2: begin
                    sel = urand(5);
                    lane = (sel < 2) ? urand(4) : (sel < 4) ? 2 * urand(2) : 0;
                    emit(enc_i(4 * urand(64) + lane, 13, load_f3[sel], rd, 7'h03));
                end
                3: begin
                    f3 = urand(2);
                    lane = (f3 == 0) ? urand(4) : 2 * urand(2);
                    emit(enc_s(32'h200 + 4 * n + lane, 1 + urand(15), 14, f3));
                end
                4: begin
                    sel = urand(4);
                    rd = 1 + urand(12);
                    if (sel < 2) begin
                        // same register on both sides half the time
                        src = 1 + urand(12);
                        emit(enc_b(8 + 4 * urand(2), urand(2) ? src : 1 + urand(12), src,
                                   br_f3[urand(6)]));
                        emit(enc_i(urand(4096), 1 + urand(12), 0, 1 + urand(12), 7'h13));
                    end else if (sel == 2) begin
                        emit(enc_j(8, rd));
                    end else begin
                        // target skips one filler, odd offset checks bit 0 clearing
                        emit(enc_i((code_w + 2) * 4 + urand(2), 0, 0, rd, 7'h67));
                    end
                    emit(enc_i(urand(4096), 1 + urand(12), 0, 1 + urand(12), 7'h13));
                end
                default: begin
                    emit(enc_u(urand(65536) * 16 + urand(16), rd, urand(2) ? 7'h37 : 7'h17));
                end
            endcase
            if (kind != 3) begin
                emit(enc_s(4 * n, rd, 14, 2));
            end
        end
        halt_addr = code_w * 4;
        emit(enc_j(0, 0));
    endtask

    // instruction-set reference model over its own memory copy
    task automatic run_model();
        word_t ins, a, b, res, addr, w, nxt, immi, imms, immb, immu, immj;
        logic [6:0] opc;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [3:0] m;
        logic       wr;
        logic       taken;
        int         steps;
        for (int i = 0; i < mem_words; i++) begin
            mmem[i] = image[i];
        end
        for (int i = 0; i < 32; i++) begin
            mx[i] = '0;
        end
        ref_fetch.delete();
        ref_wr.delete();
        w = reset_addr;
        steps = 0;
        while (w != halt_addr && steps < 4000) begin
            ref_fetch.push_back(w);
            ins = mmem[w[11:2]];
            opc = ins[6:0];
            rd = ins[11:7];
            f3 = ins[14:12];
            a = mx[ins[19:15]];
            b = mx[ins[24:20]];
            immi = word_t'($signed(ins) >>> 20);
            imms = {immi[31:5], ins[11:7]};
            immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immu = {ins[31:12], 12'b0};
            immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt = w + 32'd4;
            res = '0;
            wr = 1'b1;
            case (opc)
                7'h13, 7'h33: begin
                    if (opc == 7'h13) b = immi;
                    case (f3)
                        3'd0: res = (opc == 7'h33 && ins[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'h37: res = immu;
                7'h17: res = w + immu;
                7'h6f: begin
                    res = w + 32'd4;
                    nxt = w + immj;
                end
                7'h67: begin
                    res = w + 32'd4;
                    nxt = (a + immi) & 32'hffff_fffe;
                end
                7'h63: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: taken = a == b;
                        3'd1: taken = a != b;
                        3'd4: taken = $signed(a) < $signed(b);
                        3'd5: taken = $signed(a) >= $signed(b);
                        3'd6: taken = a < b;
                        3'd7: taken = a >= b;
                        default: taken = 1'b0;
                    endcase
                    if (taken) nxt = w + immb;
                end
                7'h03: begin
                    addr = a + immi;
                    res = mmem[addr[11:2]] >> {addr[1:0], 3'b000};
                    case (f3)
                        3'd0: res = {{24{res[7]}}, res[7:0]};
                        3'd4: res = {24'b0, res[7:0]};
                        3'd1: res = {{16{res[15]}}, res[15:0]};
                        3'd5: res = {16'b0, res[15:0]};
                        default: res = res;
                    endcase
                end
                7'h23: begin
                    wr = 1'b0;
                    addr = a + imms;
                    m = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
                        (f3 == 3'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
                    b = b << {addr[1:0], 3'b000};
                    mmem[addr[11:2]] = (mmem[addr[11:2]] & ~bytemask(m)) | (b & bytemask(m));
                    ref_wr.push_back(addr & 32'hffff_fffc);
                    ref_wr.push_back({28'b0, m});
                    ref_wr.push_back(b & bytemask(m));
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) mx[rd] = res;
            w = nxt;
            steps++;
        end
    endtask

    task automatic check(input string what, input word_t exp, input word_t act);
        assert (exp == act) else begin
            $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic run_test(input string name, input int kind);
        int cyc;
        cur_test = name;
        test_errors = 0;
        build_program(kind);
        run_model();
        dut_fetch.delete();
        dut_wr.delete();
        @(negedge clk);
        load_prog = 1'b1;
        resetn = 1'b0;
        repeat (4) @(negedge clk);
        if (kind == 0) begin
            check("pc", reset_addr, pc);
            check("mem_addr", reset_addr, mem_addr);
            check("mem_rd", 32'd1, {31'b0, mem_rd});
            check("mem_wmask", 32'd0, {28'b0, mem_wmask});
        end
        load_prog = 1'b0;
        logging = 1'b1;
        resetn = 1'b1;
        cyc = 0;
        while (pc != halt_addr && cyc < 40000) begin
            @(negedge clk);
            cyc++;
        end
        repeat (2) @(negedge clk);
        logging = 1'b0;
        if (pc != halt_addr) begin
            $display("%s: the core never reached the halt loop within the cycle limit", name);
            timed_out = 1'b1;
            test_errors++;
        end
        check("fetch count", ref_fetch.size(), dut_fetch.size());
        for (int i = 0; i < ref_fetch.size() && i < dut_fetch.size(); i++) begin
            check("fetch address", ref_fetch[i], dut_fetch[i]);
        end
        check("write log size", ref_wr.size(), dut_wr.size());
        for (int i = 0; i < ref_wr.size() && i < dut_wr.size(); i++) begin
            check("write addr/mask/data", ref_wr[i], dut_wr[i]);
        end
        for (int i = 0; i < mem_words; i++) begin
            check("memory word", mmem[i], mem[i]);
        end
        $display("%s finished with %0d errors", name, test_errors);
        errors += test_errors;
        tests_run++;
    endtask

    initial begin
        run_test("reset", 0);
        if (!timed_out) run_test("alu_ops", 1);
        if (!timed_out) run_test("loads", 2);
        if (!timed_out) run_test("stores", 3);
        if (!timed_out) run_test("control_flow", 4);
        if (!timed_out) run_test("upper_imm", 5);
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
common/rv_pkg.sv
common/decode_if.sv
core/rv_decoder.sv
core/rv_alu.sv
core/rv_regfile.sv
core/rv_mem_align.sv
core/rv_control.sv
rtl/rv_top.sv
verification/tb_clock.sv
verification/tb_rv_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_top -f sources.f -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
